/* frontend_cfg.svh */
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// reset vector, also where the core starts after the wake-up interrupt
`define FE_RESET_PC     32'h4000_0000

// no-op shown downstream while nothing valid is on the output
`define FE_BUBBLE       32'h0000_0033

// L1.5 return types
`define FE_RET_LOAD     4'b0000
`define FE_RET_IFILL    4'b0001
`define FE_RET_INT      4'b0111   // interrupt return, wakes the core

// L1.5 request fields for an instruction line read
`define FE_RQ_IFILL     5'b10000  // imiss request
`define FE_RQ_SIZE      3'b111    // full 16 byte line

// byte offset bits of a cache line
`define FE_LINE_OFFS    4

`endif

/* frontend_pkg.sv */
package frontend_pkg;

	// next pc choice from decode
	typedef enum logic [1:0]
	{
		PC_SEQ    = 2'd0,  // pc + 4
		PC_RESET  = 2'd1,  // back to the reset vector
		PC_TARGET = 2'd2,  // jump/branch target
		PC_HOLD   = 2'd3
	} pc_sel_t;

	// outstanding line read, one at a time
	typedef struct packed
	{
		logic        valid;
		logic [31:0] pc;  // full pc of the instruction asked for
	} fetch_req_t;

	// returned line, word[0] sits at the lowest address
	// word 0 = data_0[63:32], word 1 = data_0[31:0]
	// word 2 = data_1[63:32], word 3 = data_1[31:0]
	typedef struct packed
	{
		logic [3:0][31:0] word;
	} l15_line_t;

	// bundle handed to decode
	typedef struct packed
	{
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;  // bubble when not valid
	} fetch_out_t;

endpackage

/* pc_gen.sv */
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module pc_gen
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  pc_sel_t     pc_sel,
	input  logic [31:0] target,
	input  logic        redirect,
	input  logic        advance,
	output logic [31:0] pc
);

	logic [31:0] pc_q;
	logic [31:0] pc_seq;
	logic [31:0] pc_next;

	assign pc_seq = pc_q + 32'd4;

	// redirect from decode wins over a normal advance
	always_comb
	begin
		pc_next = pc_q;
		if (redirect)
		begin
			unique case (pc_sel)
				PC_SEQ:    pc_next = pc_seq;
				PC_RESET:  pc_next = `FE_RESET_PC;
				PC_TARGET: pc_next = target;
				PC_HOLD:   pc_next = pc_q;
			endcase
		end
		else if (advance)
		begin
			pc_next = pc_seq;  // one instruction delivered
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc_q <= `FE_RESET_PC;
		end
		else
		begin
			pc_q <= pc_next;
		end
	end

	assign pc = pc_q;

	// targets from decode must be word aligned, the line word select relies on it
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!nrst)
		pc_q[1:0] == 2'b00
	) else $error("pc_gen: unaligned pc %h", pc_q);

endmodule

/* l15_req.sv */
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module l15_req
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        wake,
	input  logic [31:0] pc,
	input  logic        fill_done,
	input  logic        flush,
	output logic        l15_val,
	input  logic        l15_header_ack,
	output logic [4:0]  l15_rqtype,
	output logic [2:0]  l15_size,
	output logic [31:0] l15_address,
	output fetch_req_t  req,
	output logic        stale
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_REQ,   // l15_val up, waiting for header ack
		ST_WAIT   // request out, waiting for the fill
	} state_t;

	state_t     state;
	state_t     state_next;
	fetch_req_t rec;
	logic       stale_q;
	logic       fire;

	assign fire = l15_val && l15_header_ack;

	always_comb
	begin
		state_next = state;
		unique case (state)
			ST_IDLE: if (wake && !rec.valid) state_next = ST_REQ;
			ST_REQ:  if (fire) state_next = ST_WAIT;
			ST_WAIT: if (fill_done) state_next = ST_REQ;  // wake is sticky
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state   <= ST_IDLE;
			rec     <= '0;
			stale_q <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (fire)
			begin
				rec.valid <= 1'b1;
				rec.pc    <= pc;
				stale_q   <= flush;  // redirected in the very cycle it went out
			end
			else if (fill_done)
			begin
				rec.valid <= 1'b0;
				stale_q   <= 1'b0;
			end
			else if (flush && rec.valid)
			begin
				stale_q <= 1'b1;
			end
		end
	end

	// line aligned read of the current pc
	assign l15_val     = (state == ST_REQ);
	assign l15_rqtype  = `FE_RQ_IFILL;
	assign l15_size    = `FE_RQ_SIZE;
	assign l15_address = {pc[31:`FE_LINE_OFFS], {`FE_LINE_OFFS{1'b0}}};

	assign req   = rec;
	assign stale = stale_q || (flush && rec.valid);  // a flush this cycle counts too

	a_val_held: assert property (
		@(posedge clk) disable iff (!nrst)
		l15_val && !l15_header_ack |=> l15_val
	) else $error("l15_req: l15_val dropped before header ack");

endmodule

/* l15_resp.sv */
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module l15_resp
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        resp_val,
	input  logic [3:0]  returntype,
	input  logic [63:0] data_0,
	input  logic [63:0] data_1,
	output logic        req_ack,
	output logic        wake,
	output l15_line_t   fill,
	output logic        fill_valid,
	input  logic        fill_ready
);

	logic is_fill;
	logic is_int;
	logic consumed;
	logic wake_q;

	// sort the return type into fill, interrupt and everything else
	always_comb
	begin
		is_fill = 1'b0;
		is_int  = 1'b0;
		unique case (returntype)
			`FE_RET_IFILL: is_fill = 1'b1;
			`FE_RET_INT:   is_int  = 1'b1;
			default:       ;  // loads and unknown types are only acked
		endcase
	end

	// fills wait for fetch_join while anything else is taken at once
	assign fill_valid = resp_val && is_fill;
	assign req_ack    = resp_val && (!is_fill || fill_ready);
	assign consumed   = resp_val && req_ack;

	// the first interrupt return starts the core for good
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wake_q <= 1'b0;
		end
		else if (consumed && is_int)
		begin
			wake_q <= 1'b1;
		end
	end

	assign wake = wake_q;

	// upper half of each 64 bit beat holds the lower address
	always_comb
	begin
		fill.word[0] = data_0[63:32];
		fill.word[1] = data_0[31:0];
		fill.word[2] = data_1[63:32];
		fill.word[3] = data_1[31:0];
	end

endmodule

/* fetch_join.sv */
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module fetch_join
	import frontend_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       stall,
	input  fetch_req_t req,
	input  logic       stale,
	input  l15_line_t  fill,
	input  logic       fill_valid,
	output logic       fill_ready,
	output fetch_out_t fetch_out,
	output logic       advance,
	output logic       fill_done
);

	logic        take;
	logic        deliver;
	logic        out_valid;
	logic [31:0] out_pc;
	logic [31:0] out_instr;

	assign fill_ready = !stall;  // L1.5 holds the fill while decode stalls
	assign take       = fill_valid && fill_ready;
	assign deliver    = take && !stale;  // flushed fills are eaten here

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			out_valid <= 1'b0;
			advance   <= 1'b0;
			fill_done <= 1'b0;
		end
		else
		begin
			fill_done <= take;
			advance   <= deliver;
			if (!stall)
				out_valid <= deliver;  // held as is under stall
		end
	end

	always_ff @(posedge clk)
	begin
		if (deliver)
		begin
			out_pc    <= req.pc;
			out_instr <= fill.word[req.pc[3:2]];  // word within the line
		end
	end

	always_comb
	begin
		fetch_out.valid = out_valid;
		fetch_out.pc    = out_pc;
		fetch_out.instr = out_valid ? out_instr : `FE_BUBBLE;
	end

	// the L1.5 only returns fills that l15_req asked for
	a_fill_has_req: assert property (
		@(posedge clk) disable iff (!nrst)
		fill_valid |-> req.valid
	) else $error("fetch_join: fill without outstanding request");

endmodule

/* frontend_top.sv */
`timescale 1ns/10ps

module frontend_top
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,

	// decode side
	input  logic        stall,
	input  pc_sel_t     pc_sel,
	input  logic [31:0] target,
	input  logic        redirect,
	output fetch_out_t  fetch_out,

	// L1.5 request
	output logic [4:0]  l15_rqtype,
	output logic [2:0]  l15_size,
	output logic [31:0] l15_address,
	output logic        l15_val,
	input  logic        l15_ack,         // not needed by an in-order fetch
	input  logic        l15_header_ack,

	// L1.5 response
	input  logic        l15_resp_val,
	input  logic [3:0]  l15_returntype,
	input  logic [63:0] l15_data_0,
	input  logic [63:0] l15_data_1,
	input  logic [31:0] l15_data_2,      // unused by instruction fills
	input  logic [31:0] l15_data_3,
	output logic        l15_req_ack
);

	logic [31:0] pc;
	fetch_req_t  req;
	logic        stale;
	logic        wake;
	l15_line_t   fill;
	logic        fill_valid;
	logic        fill_ready;
	logic        advance;
	logic        fill_done;

	pc_gen pc_gen_i (
		.clk(clk), .nrst(nrst),
		.pc_sel(pc_sel), .target(target), .redirect(redirect),
		.advance(advance), .pc(pc)
	);

	l15_req l15_req_i (
		.clk(clk), .nrst(nrst),
		.wake(wake), .pc(pc), .fill_done(fill_done), .flush(redirect),
		.l15_val(l15_val), .l15_header_ack(l15_header_ack),
		.l15_rqtype(l15_rqtype), .l15_size(l15_size), .l15_address(l15_address),
		.req(req), .stale(stale)
	);

	l15_resp l15_resp_i (
		.clk(clk), .nrst(nrst),
		.resp_val(l15_resp_val), .returntype(l15_returntype),
		.data_0(l15_data_0), .data_1(l15_data_1),
		.req_ack(l15_req_ack), .wake(wake),
		.fill(fill), .fill_valid(fill_valid), .fill_ready(fill_ready)
	);

	fetch_join fetch_join_i (
		.clk(clk), .nrst(nrst), .stall(stall),
		.req(req), .stale(stale),
		.fill(fill), .fill_valid(fill_valid), .fill_ready(fill_ready),
		.fetch_out(fetch_out), .advance(advance), .fill_done(fill_done)
	);

endmodule

/* tb_frontend.sv */
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module tb_frontend
	import frontend_pkg::*;
();

	logic        clk;
	logic        nrst;
	logic        stall;
	pc_sel_t     pc_sel;
	logic [31:0] target;
	logic        redirect;
	fetch_out_t  fetch_out;
	logic [4:0]  l15_rqtype;
	logic [2:0]  l15_size;
	logic [31:0] l15_address;
	logic        l15_val;
	logic        l15_ack;
	logic        l15_header_ack;
	logic        l15_resp_val;
	logic [3:0]  l15_returntype;
	logic [63:0] l15_data_0;
	logic [63:0] l15_data_1;
	logic [31:0] l15_data_2;
	logic [31:0] l15_data_3;
	logic        l15_req_ack;

	logic [31:0] pat [0:255];  // words 0..63 memory, 64.. scenario records
	logic [3:0]  inject_q[$];  // non-fill responses waiting for the model
	integer      seed = 32'hc5c7383f;
	int          errors = 0;
	int          tests = 0;
	int          cycles = 0;
	int          limit = 0;
	int          acked_cnt = 0;

	frontend_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		forever
		begin
			@(posedge clk);
			cycles++;
			if (limit > 0 && cycles > limit)
			begin
				$display("timeout: run did not finish within %0d cycles", limit);
				$display("Done: errors found");
				$finish;
			end
		end
	end

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - `FE_RESET_PC) >> 2;
		if (idx < 64)
			return pat[idx];
		return addr ^ 32'ha5a5_5a5a;  // outside the loaded region
	endfunction

	task automatic send_resp(input logic [3:0] rt, input logic [63:0] d0, input logic [63:0] d1);
		l15_resp_val   <= 1'b1;
		l15_returntype <= rt;
		l15_data_0     <= d0;
		l15_data_1     <= d1;
		do @(posedge clk); while (!l15_req_ack);  // held until taken
		l15_resp_val <= 1'b0;
	endtask

	// L1.5 model serving one line read at a time
	initial
	begin
		int          dly;
		logic [31:0] a;
		logic [3:0]  rt;
		l15_header_ack <= 1'b0;
		l15_resp_val   <= 1'b0;
		l15_returntype <= '0;
		l15_data_0     <= '0;
		l15_data_1     <= '0;
		wait (nrst);
		forever
		begin
			@(posedge clk);
			if (inject_q.size() > 0)
			begin
				rt = inject_q.pop_front();
				send_resp(rt, 64'h0bad_f00d_1234_5678, 64'h8765_4321_0f0f_f0f0);
				acked_cnt++;
			end
			else if (l15_val)
			begin
				dly = $unsigned($random(seed)) % 4;
				repeat (dly) @(posedge clk);
				l15_header_ack <= 1'b1;
				@(posedge clk);
				a = l15_address;  // value of the fire cycle
				check_val("l15_rqtype", {27'd0, `FE_RQ_IFILL}, {27'd0, l15_rqtype});
				check_val("l15_size", {29'd0, `FE_RQ_SIZE}, {29'd0, l15_size});
				l15_header_ack <= 1'b0;
				dly = $unsigned($random(seed)) % 4;
				repeat (dly) @(posedge clk);
				send_resp(`FE_RET_IFILL, {mem_word(a), mem_word(a + 4)},
					{mem_word(a + 8), mem_word(a + 12)});
			end
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_out(input string name, input logic [31:0] epc, input logic [31:0] ein);
		check_val({name, "_pc"}, epc, fetch_out.pc);
		check_val({name, "_instr"}, ein, fetch_out.instr);
	endtask

	task automatic redirect_on_fire(input pc_sel_t sel, input logic [31:0] tgt);
		do @(posedge clk); while (!(l15_val && l15_header_ack));
		redirect <= 1'b1;  // request just went out so its fill is stale
		pc_sel   <= sel;
		target   <= tgt;
		@(posedge clk);
		redirect <= 1'b0;
	endtask

	initial
	begin
		int          k;
		int          e0;
		int          n0;
		logic [31:0] op;
		logic [31:0] arg;
		logic [31:0] epc;
		logic [31:0] ein;
		string       name;
		stall          <= 1'b0;
		pc_sel         <= PC_SEQ;
		target         <= '0;
		redirect       <= 1'b0;
		l15_ack        <= 1'b0;
		l15_data_2     <= '0;
		l15_data_3     <= '0;
		nrst           <= 1'b0;
		for (k = 0; k < 256; k++)
			pat[k] = (`FE_RESET_PC + k * 4) ^ 32'ha5a5_5a5a;
		$readmemh("frontend_patterns.txt", pat);
		k = 64;
		while (k < 256 && pat[k] != 0)
			k += 4;
		limit = 20 + 40 * ((k - 64) / 4);
		repeat (4) @(posedge clk);
		nrst <= 1'b1;
		for (k = 64; k < 256 && pat[k] != 0; k += 4)
		begin
			op   = pat[k];
			arg  = pat[k + 1];
			epc  = pat[k + 2];
			ein  = pat[k + 3];
			e0   = errors;
			name = $sformatf("rec%0d_op%0d", (k - 64) / 4, op);
			case (op)
				1:
				begin
					repeat (10)
					begin
						@(posedge clk);
						if (l15_val || fetch_out.valid)
						begin
							$display("%s: fetch activity before the wake-up interrupt", name);
							errors++;
						end
					end
					inject_q.push_back(`FE_RET_INT);
					do @(posedge clk); while (!l15_val);
					check_val({name, "_addr"}, arg, l15_address);
				end
				2:
				begin
					do @(posedge clk); while (!fetch_out.valid);
					check_out(name, epc, ein);
				end
				3: redirect_on_fire(PC_TARGET, arg);
				4: redirect_on_fire(PC_RESET, arg);
				5:
				begin
					// stall goes up in the cycle the instruction shows
					do @(posedge clk);
					while (!(l15_resp_val && l15_req_ack && l15_returntype == `FE_RET_IFILL));
					stall <= 1'b1;
					repeat (arg)
					begin
						@(posedge clk);
						check_val({name, "_valid"}, 32'd1, {31'd0, fetch_out.valid});
						check_out(name, epc, ein);
					end
					stall <= 1'b0;
					@(posedge clk);
					check_val({name, "_valid"}, 32'd1, {31'd0, fetch_out.valid});
					check_out(name, epc, ein);  // last cycle it is visible
				end
				6:
				begin
					n0 = acked_cnt;
					inject_q.push_back(arg[3:0]);
					while (acked_cnt == n0)
						@(posedge clk);
				end
				default:
				begin
					$display("%s: unknown operation in the pattern file", name);
					errors++;
				end
			endcase
			tests++;
			$display("test %s %s", name, (errors == e0) ? "ok" : "failed");
		end
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* frontend_patterns.txt */
// words @0 and @20: instruction memory from 40000000, one word per address
// words @40: records of op, argument, expected pc, expected instruction; op 0 ends
@0
00100093 00200113 00300193 00400213
00500293 00600313 00700393 00800413
00900493 00a00513 00b00593 00c00613
00d00693 00e00713 00f00793 01000813
@20
08000e93 08400f13 08800f93 08c01013
09001093 09401113 09801193 09c01213
@40
00000001 40000000 00000000 00000000  // wake-up, first request address
00000002 00000000 40000000 00100093
00000002 00000000 40000004 00200113
00000002 00000000 40000008 00300193
00000002 00000000 4000000c 00400213
00000002 00000000 40000010 00500293
00000002 00000000 40000014 00600313
00000002 00000000 40000018 00700393
00000002 00000000 4000001c 00800413
00000005 00000003 40000020 00900493  // stall for 3 cycles
00000002 00000000 40000024 00a00513
00000006 00000000 00000000 00000000  // load return
00000006 00000005 00000000 00000000  // other return type
00000002 00000000 40000028 00b00593
00000003 40000088 00000000 00000000  // redirect to target
00000002 00000000 40000088 08800f93
00000002 00000000 4000008c 08c01013
00000002 00000000 40000090 09001093
00000004 00000000 00000000 00000000  // redirect to reset vector
00000002 00000000 40000000 00100093
00000002 00000000 40000004 00200113
00000000 00000000 00000000 00000000

/* verilog.f */
+incdir+.
frontend_pkg.sv
pc_gen.sv
l15_req.sv
l15_resp.sv
fetch_join.sv
frontend_top.sv
tb_frontend.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_frontend
FILELIST  = verilog.f
PASS_MSG  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
